//--- include/cart_defs.svh
// Cartridge mapper constants for the SDRAM layout and the bank table

`ifndef CART_DEFS_SVH
`define CART_DEFS_SVH

// ********************
// SDRAM layout
// ********************

// C64 RAM sits at the bottom of SDRAM, 256K per region
`define CART_RAM_BASE 7'h00
// CRT banks start at 1M, one 8K slot per bank
`define CART_CRT_BASE 5'h01

// ********************
// Bank table
// ********************

`define CART_BANKS  64  // Entries per page table
`define CART_BANK_W 7   // Bank / page number width
`define CART_ADDR_W 25  // SDRAM word address width

`endif

//--- hdl/cart_pkg.sv
// Cartridge side types shared by the loader, the bank logic and the CPU bus
`default_nettype none

`include "cart_defs.svh"

package cart_pkg;

	// Cart ids taken from the CRT header
	typedef enum logic [15:0] {
		CART_GENERIC     = 16'd0,
		CART_OCEAN       = 16'd5,
		CART_MAGIC_DESK  = 16'd19,
		CART_EASYFLASH   = 16'd32,
		CART_EASYFLASH_X = 16'd33,  // XBank, same banking as EasyFlash
		CART_NONE        = 16'd255
	} cart_type_t;

	typedef logic [`CART_BANK_W-1:0] bank_t;

	// One CHIP packet from the CRT loader
	typedef struct packed {
		logic                   wr;     // Single cycle strobe per bank
		logic [15:0]            num;    // Bank number
		logic [15:0]            laddr;  // C64 load address
		logic [15:0]            size;   // Bank size in bytes
		logic [`CART_ADDR_W-1:0] raddr; // Where the loader put the data
	} cart_load_t;

	// CPU side of the expansion port
	typedef struct packed {
		logic [17:0] addr;
		logic [7:0]  data;
		logic        mem_write;
		logic        mem_ce;
		logic        roml;  // $8000-$9FFF window
		logic        romh;  // $A000-$BFFF or $E000-$FFFF window
		logic        ioe;   // $DExx select
	} cpu_bus_t;

endpackage

`default_nettype wire

//--- hdl/mem_map_pkg.sv
// Memory side types for the translated SDRAM request
`default_nettype none

`include "cart_defs.svh"

package mem_map_pkg;

	typedef logic [`CART_ADDR_W-1:0] sdram_addr_t;

	// ********************
	// Mapper output
	// ********************

	typedef struct packed {
		sdram_addr_t addr;
		logic        mem_write;      // Write strobe after the ultimax gate
		logic        data_floating;  // No ROM behind this read
	} map_out_t;

endpackage

`default_nettype wire

//--- hdl/bank_table.sv
// Bank table holding the SDRAM start page of each CRT bank as it is loaded
`timescale 1ns/10ps
`default_nettype none

`include "cart_defs.svh"

module bank_table import cart_pkg::*; (
	input  logic       clk32,
	input  logic       reset_n,
	input  logic       cart_loading,
	input  cart_load_t load,
	input  bank_t      lo_idx,
	input  bank_t      hi_idx,
	output bank_t      lo_page,
	output bank_t      hi_page,
	output logic [7:0] bank_cnt,
	output logic       big_load
);

	localparam int IDX_W = $clog2(`CART_BANKS);

	bank_t lo_mem [0:`CART_BANKS-1];  // Page of the $8000 half
	bank_t hi_mem [0:`CART_BANKS-1];  // Page of the $A000/$E000 half

	logic             loading_q;
	logic [IDX_W-1:0] wr_idx;
	bank_t            wr_page;
	logic             wr_hit;

	assign wr_idx  = load.num[IDX_W-1:0];
	assign wr_page = load.raddr[19:13];  // 8K page inside the CRT region
	assign wr_hit  = load.wr && (load.num < `CART_BANKS);

	always_ff @(posedge clk32) begin
		if (wr_hit) begin
			if (load.laddr <= 16'h8000) begin
				lo_mem[wr_idx] <= wr_page;
				// 16K chip spills into the next page
				if (load.size > 16'h2000)
					hi_mem[wr_idx] <= bank_t'(wr_page + 1'b1);
			end else begin
				hi_mem[wr_idx] <= wr_page;
			end
		end
	end

	always_ff @(posedge clk32) begin
		if (reset_n) begin
			loading_q <= 1'b0;
			bank_cnt  <= '0;
			big_load  <= 1'b0;
		end else begin
			loading_q <= cart_loading;
			if (cart_loading && !loading_q) begin  // New file starts
				bank_cnt <= '0;
				big_load <= 1'b0;
			end
			if (load.wr) begin
				bank_cnt <= bank_cnt + 8'd1;
				if (load.num >= 16'd32) big_load <= 1'b1;
			end
		end
	end

	assign lo_page = lo_mem[lo_idx[IDX_W-1:0]];
	assign hi_page = hi_mem[hi_idx[IDX_W-1:0]];

endmodule

`default_nettype wire

//--- hdl/bank_control.sv
// Banking registers and EXROM/GAME control for the supported C64 cart types
`timescale 1ns/10ps
`default_nettype none

module bank_control import cart_pkg::*; (
	input  logic       clk32,
	input  logic       reset_n,
	input  cart_type_t cart_id,
	input  logic [7:0] cart_exrom,
	input  logic [7:0] cart_game,
	input  cpu_bus_t   bus,
	input  bank_t      lo_page,
	input  bank_t      hi_page,
	input  logic [7:0] bank_cnt,
	input  logic       big_load,
	output bank_t      lo_idx,
	output bank_t      hi_idx,
	output bank_t      bank_lo,
	output bank_t      bank_hi,
	output logic       lo_en,
	output logic       hi_en,
	output logic       exrom,
	output logic       game
);

	logic       ioe_q;
	cart_type_t id_q;
	logic       init_n;   // Low for the first cycle after reset
	logic       cart_rst;
	logic       ioe_wr;
	logic       is_ef;
	logic [7:0] d;

	assign d        = bus.data;
	assign ioe_wr   = bus.ioe && !ioe_q && bus.mem_write;
	assign cart_rst = reset_n || (cart_id != id_q);  // New cart type restarts the cart
	assign is_ef    = (cart_id == CART_EASYFLASH) || (cart_id == CART_EASYFLASH_X);

	// EasyFlash bank writes look up the table in the same cycle
	assign lo_idx = (is_ef && ioe_wr && !bus.addr[1]) ? bank_t'(d[5:0]) : '0;
	assign hi_idx = lo_idx;

	always_ff @(posedge clk32) begin
		ioe_q  <= bus.ioe;
		id_q   <= cart_id;
		init_n <= 1'b1;

		if (cart_rst) begin
			init_n  <= 1'b0;
			bank_lo <= '0;
			bank_hi <= '0;
			lo_en   <= 1'b0;
			hi_en   <= 1'b0;
			exrom   <= 1'b1;  // Cart off the bus
			game    <= 1'b1;
		end else begin
			lo_en <= 1'b1;
			hi_en <= 1'b1;

			case (cart_id)
				// ********************
				// Generic 8K / 16K / ultimax
				// ********************
				CART_GENERIC: begin
					exrom   <= cart_exrom[0];
					game    <= cart_game[0];
					bank_lo <= lo_page;
					bank_hi <= hi_page;
				end

				// Ocean type 1, same bank in both windows
				CART_OCEAN: begin
					if (!init_n) begin
						exrom <= 1'b0;
						game  <= 1'b0;
					end
					if (ioe_wr) begin
						bank_lo <= bank_t'(d[5:0]);
						bank_hi <= bank_t'(d[5:0]);
					end
					if (big_load) game <= 1'b1;  // 512K variant, ROMH is RAM
				end

				// Magic Desk, 8K mode with bank mask from the file size
				CART_MAGIC_DESK: begin
					if (!init_n) begin
						exrom   <= 1'b0;
						game    <= 1'b1;
						bank_lo <= '0;
					end
					if (ioe_wr) begin
						if (bank_cnt <= 8'd16)      bank_lo <= bank_t'(d[3:0]);
						else if (bank_cnt <= 8'd32) bank_lo <= bank_t'(d[4:0]);
						else if (bank_cnt <= 8'd64) bank_lo <= bank_t'(d[5:0]);
						else                        bank_lo <= d[6:0];
						exrom <= d[7];  // Bit 7 switches the cart off
					end
				end

				// ********************
				// EasyFlash and XBank
				// ********************
				CART_EASYFLASH, CART_EASYFLASH_X: begin
					if (!init_n) begin
						exrom   <= (cart_id == CART_EASYFLASH);  // Type 32 boots ultimax
						game    <= 1'b0;
						bank_lo <= lo_page;
						bank_hi <= hi_page;
					end
					if (ioe_wr) begin
						if (bus.addr[1]) begin  // $DE02 control
							game  <= d[2] & ~d[0];
							exrom <= ~d[1];
						end else begin          // $DE00 bank
							bank_lo <= lo_page;
							bank_hi <= hi_page;
						end
					end
				end

				default: begin
					lo_en <= 1'b0;
					hi_en <= 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/addr_mapper.sv
// Address mapper from the CPU bus to SDRAM for RAM and cartridge ROM windows
`timescale 1ns/10ps
`default_nettype none

`include "cart_defs.svh"

module addr_mapper
	import cart_pkg::*;
	import mem_map_pkg::*;
(
	input  cpu_bus_t bus,
	input  bank_t    bank_lo,
	input  bank_t    bank_hi,
	input  logic     lo_en,
	input  logic     hi_en,
	input  logic     exrom,
	input  logic     game,
	output map_out_t map
);

	logic rd;
	logic ultimax;

	assign rd      = bus.mem_ce && !bus.mem_write;
	assign ultimax = exrom && !game;

	// ********************
	// Translation
	// ********************

	always_comb begin
		map.addr          = {`CART_RAM_BASE, bus.addr};
		map.data_floating = 1'b0;

		// No RAM under ROML in ultimax mode
		map.mem_write = bus.mem_write && !(bus.roml && ultimax);

		if (bus.romh && rd) begin
			map.addr          = {`CART_CRT_BASE, bank_hi, bus.addr[12:0]};
			map.data_floating = !hi_en;
		end

		if (bus.roml && rd) begin
			map.addr          = {`CART_CRT_BASE, bank_lo, bus.addr[12:0]};
			map.data_floating = !lo_en;  // Empty slot reads as open bus
		end
	end

endmodule

`default_nettype wire

//--- hdl/cart_mapper_top.sv
// Cartridge bank mapper top level joining bank table, bank control and address mapper
`timescale 1ns/10ps
`default_nettype none

module cart_mapper_top
	import cart_pkg::*;
	import mem_map_pkg::*;
(
	input  logic       clk32,
	input  logic       reset_n,
	input  logic       cart_loading,
	input  cart_type_t cart_id,
	input  logic [7:0] cart_exrom,
	input  logic [7:0] cart_game,
	input  cart_load_t load,
	input  cpu_bus_t   bus,
	output logic       exrom,
	output logic       game,
	output map_out_t   map
);

	bank_t      lo_idx, hi_idx;
	bank_t      lo_page, hi_page;
	bank_t      bank_lo, bank_hi;
	logic [7:0] bank_cnt;
	logic       big_load;
	logic       lo_en, hi_en;

	bank_table bank_table_i (
		.clk32, .reset_n, .cart_loading, .load,
		.lo_idx, .hi_idx, .lo_page, .hi_page, .bank_cnt, .big_load
	);

	bank_control bank_control_i (
		.clk32, .reset_n, .cart_id, .cart_exrom, .cart_game, .bus,
		.lo_page, .hi_page, .bank_cnt, .big_load,
		.lo_idx, .hi_idx, .bank_lo, .bank_hi, .lo_en, .hi_en, .exrom, .game
	);

	addr_mapper addr_mapper_i (
		.bus, .bank_lo, .bank_hi, .lo_en, .hi_en, .exrom, .game, .map
	);

endmodule

`default_nettype wire

//--- bench/cart_checker.sv
// Checker that mirrors the cart mapper state and compares the DUT outputs every cycle
`timescale 1ns/10ps
`default_nettype none

`include "cart_defs.svh"

module cart_checker
	import cart_pkg::*;
	import mem_map_pkg::*;
(
	input  logic       clk32,
	input  logic       reset_n,
	input  logic       cart_loading,
	input  cart_type_t cart_id,
	input  logic [7:0] cart_exrom,
	input  logic [7:0] cart_game,
	input  cart_load_t load,
	input  cpu_bus_t   bus,
	input  logic       exrom,
	input  logic       game,
	input  map_out_t   map,
	input  logic       test_done,
	input  logic       report,
	input  logic [3:0] test_num,
	output int         err_cnt
);

	bank_t      tbl_lo [0:`CART_BANKS-1];
	bank_t      tbl_hi [0:`CART_BANKS-1];
	bank_t      m_lo, m_hi;
	logic       m_lo_en, m_hi_en, m_exrom, m_game;
	logic       m_ioe, m_init, m_ld, m_big, armed;
	logic [7:0] m_cnt;
	cart_type_t m_id;
	int         checks, errs, tests;

	// Expected SDRAM request for the current bus cycle
	function automatic map_out_t expect_map(input cpu_bus_t b);
		map_out_t m;
		logic     rd;
		rd              = b.mem_ce && !b.mem_write;
		m.addr          = {`CART_RAM_BASE, b.addr};
		m.data_floating = 1'b0;
		m.mem_write     = b.mem_write && !(b.roml && m_exrom && !m_game);  // Ultimax gate
		if (rd && (b.roml || b.romh)) begin
			m.addr          = {`CART_CRT_BASE, b.roml ? m_lo : m_hi, b.addr[12:0]};
			m.data_floating = b.roml ? !m_lo_en : !m_hi_en;
		end
		return m;
	endfunction

	// ********************
	// Mirror of table and registers
	// ********************

	always @(posedge clk32) begin
		logic [7:0] d;
		logic       wr;
		logic       rst;
		bank_t      page;
		bank_t      mask;
		d    = bus.data;
		wr   = bus.ioe && !m_ioe && bus.mem_write;  // Rising IOE with a write
		rst  = reset_n || (cart_id != m_id);
		page = load.raddr[19:13];
		mask = (m_cnt <= 8'd16) ? 7'h0F : (m_cnt <= 8'd32) ? 7'h1F :
			(m_cnt <= 8'd64) ? 7'h3F : 7'h7F;

		if (load.wr && load.num < 16'(`CART_BANKS)) begin
			if (load.laddr > 16'h8000) begin
				tbl_hi[load.num[5:0]] <= page;  // ROMH only chip
			end else begin
				tbl_lo[load.num[5:0]] <= page;
				if (load.size > 16'h2000)
					tbl_hi[load.num[5:0]] <= page + 7'd1;
			end
		end

		if (reset_n) begin
			m_ld  <= 1'b0;
			m_cnt <= '0;
			m_big <= 1'b0;
		end else begin
			m_ld <= cart_loading;
			if (cart_loading && !m_ld) begin
				m_cnt <= '0;
				m_big <= 1'b0;
			end
			if (load.wr) begin
				m_cnt <= m_cnt + 8'd1;
				if (load.num > 16'd31)
					m_big <= 1'b1;
			end
		end

		m_ioe  <= bus.ioe;
		m_id   <= cart_id;
		m_init <= rst;  // Start values are due next cycle
		armed  <= armed || reset_n;

		if (rst) begin
			m_lo    <= '0;
			m_hi    <= '0;
			m_lo_en <= 1'b0;
			m_hi_en <= 1'b0;
			m_exrom <= 1'b1;
			m_game  <= 1'b1;
		end else begin
			m_lo_en <= 1'b1;
			m_hi_en <= 1'b1;
			case (cart_id)
				CART_GENERIC: begin
					m_exrom <= cart_exrom[0];
					m_game  <= cart_game[0];
					m_lo    <= tbl_lo[0];
					m_hi    <= tbl_hi[0];
				end
				CART_OCEAN: begin
					if (m_init) begin
						m_exrom <= 1'b0;
						m_game  <= 1'b0;
					end
					if (wr) begin
						m_lo <= {1'b0, d[5:0]};
						m_hi <= {1'b0, d[5:0]};
					end
					if (m_big)
						m_game <= 1'b1;
				end
				CART_MAGIC_DESK: begin
					if (m_init) begin
						m_exrom <= 1'b0;
						m_game  <= 1'b1;
						m_lo    <= '0;
					end
					if (wr) begin
						m_lo    <= d[6:0] & mask;  // Mask follows the loaded bank count
						m_exrom <= d[7];
					end
				end
				CART_EASYFLASH, CART_EASYFLASH_X: begin
					if (m_init) begin
						m_exrom <= (cart_id == CART_EASYFLASH);
						m_game  <= 1'b0;
						m_lo    <= tbl_lo[0];
						m_hi    <= tbl_hi[0];
					end
					if (wr && bus.addr[1]) begin
						m_game  <= d[2] & ~d[0];
						m_exrom <= ~d[1];
					end else if (wr) begin
						m_lo <= tbl_lo[d[5:0]];
						m_hi <= tbl_hi[d[5:0]];
					end
				end
				default: begin
					m_lo_en <= 1'b0;
					m_hi_en <= 1'b0;
				end
			endcase
		end
	end

	// ********************
	// Compare and report
	// ********************

	always @(negedge clk32) begin
		map_out_t exp_map;
		exp_map = expect_map(bus);
		if (armed) begin
			checks = checks + 1;
			if (exrom !== m_exrom || game !== m_game) begin
				$display("FAIL %0t: EXROM/GAME %b/%b, expected %b/%b",
					$time, exrom, game, m_exrom, m_game);
				errs    = errs + 1;
				err_cnt = err_cnt + 1;
			end
			if (map !== exp_map) begin
				$display("FAIL %0t: map addr %h wr %b float %b, expected %h %b %b", $time,
					map.addr, map.mem_write, map.data_floating,
					exp_map.addr, exp_map.mem_write, exp_map.data_floating);
				errs    = errs + 1;
				err_cnt = err_cnt + 1;
			end
		end
		if (test_done) begin
			$display("Test %0d done: %0d checks, %0d errors", test_num, checks, errs);
			tests  = tests + 1;
			checks = 0;
			errs   = 0;
		end
		if (report)
			$display("Summary: %0d tests, %0d errors", tests, err_cnt);
	end

endmodule

`default_nettype wire

//--- bench/cart_tb.sv
// Testbench for the cartridge bank mapper driving loads, IOE writes and CPU accesses
`timescale 1ns/10ps
`default_nettype none

module cart_tb
	import cart_pkg::*;
	import mem_map_pkg::*;
();

	localparam int TIMEOUT = 40;  // Cycles per wait

	logic        clk32 = 1'b0;
	logic        reset_n, cart_loading, exrom, game;
	logic        test_done, report;
	logic [3:0]  test_num;
	logic [7:0]  cart_exrom, cart_game;
	logic [31:0] seed = 32'd21;
	int          err_cnt;
	cart_type_t  cart_id;
	cart_load_t  load;
	cpu_bus_t    bus;
	map_out_t    map;

	always #10 clk32 = ~clk32;

	cart_mapper_top cart_mapper_top_i (
		.clk32, .reset_n, .cart_loading, .cart_id, .cart_exrom, .cart_game,
		.load, .bus, .exrom, .game, .map
	);

	cart_checker cart_checker_i (
		.clk32, .reset_n, .cart_loading, .cart_id, .cart_exrom, .cart_game, .load, .bus,
		.exrom, .game, .map, .test_done, .report, .test_num, .err_cnt
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// ********************
	// Bus sequences
	// ********************

	task automatic load_banks(input int first, input int count, input logic [15:0] laddr,
			input logic [15:0] size);
		cart_loading <= 1'b1;
		@(posedge clk32);
		for (int i = 0; i < count; i++) begin
			seed = lcg_step(seed);
			load <= '{wr: 1'b1, num: 16'(first + i), laddr: laddr, size: size,
				raddr: seed[31:7]};
			@(posedge clk32);
		end
		load.wr      <= 1'b0;
		cart_loading <= 1'b0;
		@(posedge clk32);
	endtask

	// One access and then an idle cycle with sel as {roml, romh, ioe}
	task automatic cpu_cycle(input logic [17:0] addr, input logic [7:0] data, input logic wr,
			input logic [2:0] sel);
		bus <= '{addr: addr, data: data, mem_write: wr, mem_ce: 1'b1,
			roml: sel[2], romh: sel[1], ioe: sel[0]};
		@(posedge clk32);
		bus <= '0;
		@(posedge clk32);
	endtask

	task automatic rom_reads(input int n);
		for (int i = 0; i < n; i++) begin
			seed = lcg_step(seed);
			cpu_cycle({5'b00100, seed[20:8]}, 8'h00, 1'b0, 3'b100);  // ROML
			cpu_cycle({5'b00101, seed[20:8]}, 8'h00, 1'b0, 3'b010);  // ROMH
			cpu_cycle(seed[31:14], 8'h00, 1'b0, 3'b000);
		end
	endtask

	task automatic ioe_writes(input int n, input logic [17:0] addr, input logic [7:0] mask);
		for (int i = 0; i < n; i++) begin
			seed = lcg_step(seed);
			cpu_cycle(addr, seed[23:16] & mask, 1'b1, 3'b001);
			rom_reads(1);
		end
	endtask

	task automatic wait_outputs(input logic exp_exrom, input logic exp_game);
		int n;
		n = 0;
		@(negedge clk32);
		while (!(exrom === exp_exrom && game === exp_game) && n < TIMEOUT) begin
			n++;
			@(negedge clk32);
		end
		if (!(exrom === exp_exrom && game === exp_game)) begin
			$display("Timeout waiting for EXROM/GAME to become %b/%b", exp_exrom, exp_game);
			$display("=== FAIL ===");
			$finish;
		end else begin
			@(posedge clk32);
		end
	endtask

	// Reset state first and then the start values of the new type
	task automatic change_type(input cart_type_t id, input logic exp_exrom, input logic exp_game);
		cart_id <= id;
		@(posedge clk32);
		wait_outputs(1'b1, 1'b1);
		wait_outputs(exp_exrom, exp_game);
	endtask

	task automatic finish_test(input logic [3:0] num);
		test_num  <= num;
		test_done <= 1'b1;
		@(posedge clk32);
		test_done <= 1'b0;
	endtask

	initial begin
		reset_n      <= 1'b1;
		cart_loading <= 1'b0;
		cart_id      <= CART_GENERIC;
		cart_exrom   <= 8'h00;
		cart_game    <= 8'h00;
		load         <= '0;
		bus          <= '0;
		test_done    <= 1'b0;
		test_num     <= '0;
		report       <= 1'b0;
		repeat (10) @(posedge clk32);
		reset_n <= 1'b0;
		wait_outputs(1'b0, 1'b0);

		load_banks(0, 1, 16'h8000, 16'h4000);  // Generic 16K
		rom_reads(4);
		cart_exrom <= 8'h01;
		rom_reads(2);
		cart_exrom <= 8'h00;
		cart_game  <= 8'h01;
		rom_reads(2);
		finish_test(1);

		change_type(CART_OCEAN, 1'b0, 1'b0);
		load_banks(0, 16, 16'h8000, 16'h2000);
		ioe_writes(6, 18'h0DE00, 8'hFF);
		load_banks(30, 4, 16'h8000, 16'h2000);  // Reaches bank 32
		wait_outputs(1'b0, 1'b1);
		rom_reads(2);
		finish_test(2);

		change_type(CART_MAGIC_DESK, 1'b0, 1'b1);
		load_banks(0, 16, 16'h8000, 16'h2000);
		ioe_writes(5, 18'h0DE00, 8'hFF);
		load_banks(0, 64, 16'h8000, 16'h2000);
		ioe_writes(5, 18'h0DE00, 8'hFF);
		cpu_cycle(18'h0DE00, 8'h8A, 1'b1, 3'b001);  // Cart off
		cpu_cycle(18'h0DE00, 8'h35, 1'b1, 3'b001);
		rom_reads(1);
		finish_test(3);

		change_type(CART_EASYFLASH, 1'b1, 1'b0);
		load_banks(0, 8, 16'h8000, 16'h4000);
		load_banks(8, 1, 16'hA000, 16'h2000);
		cpu_cycle(18'h0DE00, 8'h08, 1'b1, 3'b001);
		rom_reads(1);
		ioe_writes(4, 18'h0DE00, 8'hC7);
		ioe_writes(4, 18'h0DE02, 8'hFF);
		finish_test(4);

		cpu_cycle(18'h0DE02, 8'h00, 1'b1, 3'b001);  // Ultimax
		wait_outputs(1'b1, 1'b0);
		cpu_cycle({5'b00100, 13'h0123}, 8'h5A, 1'b1, 3'b100);
		cpu_cycle(18'h01234, 8'hA5, 1'b1, 3'b000);
		change_type(CART_NONE, 1'b1, 1'b1);
		rom_reads(3);
		finish_test(5);

		change_type(CART_OCEAN, 1'b0, 1'b0);
		change_type(CART_EASYFLASH_X, 1'b0, 1'b0);
		change_type(CART_EASYFLASH, 1'b1, 1'b0);
		change_type(CART_GENERIC, 1'b0, 1'b1);
		finish_test(6);

		report <= 1'b1;
		@(posedge clk32);
		report <= 1'b0;
		@(posedge clk32);
		if (err_cnt == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- cart_mapper.f
+incdir+include
hdl/cart_pkg.sv
hdl/mem_map_pkg.sv
hdl/bank_table.sv
hdl/bank_control.sv
hdl/addr_mapper.sv
hdl/cart_mapper_top.sv
bench/cart_checker.sv
bench/cart_tb.sv

//--- Makefile
# Verilator build and run for the cartridge bank mapper

VERILATOR ?= verilator
TOP       ?= cart_tb
FLIST     ?= cart_mapper.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)
